//--- logic/ship_pkg.sv
package ship_pkg;

  // pixel bus widths
  localparam int COORD_W = 11;
  localparam int RGB_W   = 12;

  localparam int SCREEN_W = 800;

  // player ship
  localparam int SHIP_Y    = 540;
  localparam int SHIP_W    = 32;
  localparam int SHIP_H    = 32;
  localparam int SHIP_X0   = 384;
  localparam int SHIP_STEP = 4;
  localparam logic [RGB_W-1:0] SHIP_RGB = 12'h0f0;

  // player missile
  localparam int MIS_W    = 4;
  localparam int MIS_H    = 12;
  localparam int MIS_STEP = 8;
  localparam logic [RGB_W-1:0] MIS_RGB = 12'hff0;

  // lives and the dead period
  localparam int LIVES_MAX   = 3;
  localparam int DEAD_FRAMES = 4;

  // life icons, stacked down the left edge
  localparam int LIFE_X     = 30;
  localparam int LIFE_Y0    = 50;
  localparam int LIFE_PITCH = 50;
  localparam int LIFE_SZ    = 32;
  localparam logic [RGB_W-1:0] LIFE_RGB = 12'hf00;

  localparam int ENEMY_N = 3;

  typedef struct packed {
    logic [COORD_W-1:0] vcount;
    logic               vsync;
    logic               vblnk;
    logic [COORD_W-1:0] hcount;
    logic               hsync;
    logic               hblnk;
    logic [RGB_W-1:0]   rgb;
  } vga_t;

  // top-left corner plus visible flag
  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               on;
  } obj_t;

  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } point_t;

  typedef enum logic [1:0] {ALIVE, DEAD, OVER} ship_state_e;

endpackage

//--- logic/ship_ctl.sv
module ship_ctl
  import ship_pkg::*;
(
  input  logic               pclk,
  input  logic               rst_n_i,
  input  logic               vsync_i,
  input  logic               left_i,
  input  logic               right_i,
  input  logic               dead_i,
  output logic               frame_tick_o,
  output logic [COORD_W-1:0] ship_x_o
);

  logic vsync_q;

  // rising edge of vsync marks a new frame
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vsync_q      <= 1'b0;
      frame_tick_o <= 1'b0;
    end else begin
      vsync_q      <= vsync_i;
      frame_tick_o <= vsync_i && !vsync_q;
    end
  end

  // one step per frame, held inside the screen
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ship_x_o <= COORD_W'(SHIP_X0);
    end else if (frame_tick_o && !dead_i) begin
      if (left_i && !right_i) begin
        if (ship_x_o < COORD_W'(SHIP_STEP)) begin
          ship_x_o <= '0;
        end else begin
          ship_x_o <= ship_x_o - COORD_W'(SHIP_STEP);
        end
      end else if (right_i && !left_i) begin
        if (ship_x_o >= COORD_W'(SCREEN_W - SHIP_W - SHIP_STEP)) begin
          ship_x_o <= COORD_W'(SCREEN_W - SHIP_W);
        end else begin
          ship_x_o <= ship_x_o + COORD_W'(SHIP_STEP);
        end
      end
    end
  end

endmodule

//--- logic/hit_detect.sv
module hit_detect
  import ship_pkg::*;
(
  input  logic                       pclk,
  input  logic                       rst_n_i,
  input  logic                       frame_tick_i,
  input  logic [COORD_W-1:0]         ship_x_i,
  input  point_t [ENEMY_N-1:0]       enemy_i,
  output logic                       dead_o,
  output logic [1:0]                 lives_o
);

  ship_state_e                      state;
  logic [$clog2(DEAD_FRAMES)-1:0]   dead_cnt;
  logic                             hit;

  // any enemy point inside the ship box
  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < ENEMY_N; i++) begin
      if (enemy_i[i].x >= ship_x_i &&
          enemy_i[i].x < ship_x_i + COORD_W'(SHIP_W) &&
          enemy_i[i].y >= COORD_W'(SHIP_Y) &&
          enemy_i[i].y < COORD_W'(SHIP_Y + SHIP_H)) begin
        hit = 1'b1;
      end
    end
  end

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state    <= ALIVE;
      lives_o  <= 2'(LIVES_MAX);
      dead_cnt <= '0;
    end else if (frame_tick_i) begin
      case (state)
        ALIVE: begin
          if (hit) begin
            lives_o  <= lives_o - 2'd1;
            dead_cnt <= '0;
            // last life gone, stay down for good
            if (lives_o == 2'd1) begin
              state <= OVER;
            end else begin
              state <= DEAD;
            end
          end
        end
        DEAD: begin
          if (int'(dead_cnt) == DEAD_FRAMES - 1) begin
            state <= ALIVE;
          end else begin
            dead_cnt <= dead_cnt + 1'b1;
          end
        end
        default: begin
          state <= OVER;
        end
      endcase
    end
  end

  assign dead_o = (state != ALIVE);

endmodule

//--- logic/missile_ctl.sv
module missile_ctl
  import ship_pkg::*;
(
  input  logic               pclk,
  input  logic               rst_n_i,
  input  logic               frame_tick_i,
  input  logic               fire_i,
  input  logic [COORD_W-1:0] ship_x_i,
  input  logic               dead_i,
  output obj_t               missile_o
);

  logic launch;
  logic retire;

  // launch only from rest, flight only while on
  assign launch = !missile_o.on && fire_i && !dead_i;
  assign retire = missile_o.on && (missile_o.y < COORD_W'(MIS_STEP));

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      missile_o <= '0;
    end else if (frame_tick_i) begin
      if (launch) begin
        // centred over the ship, just above its top row
        missile_o.x  <= ship_x_i + COORD_W'(SHIP_W / 2 - MIS_W / 2);
        missile_o.y  <= COORD_W'(SHIP_Y - MIS_H);
        missile_o.on <= 1'b1;
      end else if (retire) begin
        missile_o.on <= 1'b0;
      end else if (missile_o.on) begin
        missile_o.y <= missile_o.y - COORD_W'(MIS_STEP);
      end
    end
  end

endmodule

//--- logic/draw_rect.sv
module draw_rect
  import ship_pkg::*;
#(
  parameter int               WIDTH  = 16,
  parameter int               HEIGHT = 16,
  parameter logic [RGB_W-1:0] COLOR  = 12'hfff
) (
  input  logic pclk,
  input  logic rst_n_i,
  input  obj_t obj_i,
  input  vga_t vga_i,
  output vga_t vga_o
);

  logic in_rect;
  logic paint;

  assign in_rect = (vga_i.hcount >= obj_i.x) &&
                   (vga_i.hcount < obj_i.x + COORD_W'(WIDTH)) &&
                   (vga_i.vcount >= obj_i.y) &&
                   (vga_i.vcount < obj_i.y + COORD_W'(HEIGHT));

  // never paint during blanking
  assign paint = obj_i.on && in_rect && !vga_i.hblnk && !vga_i.vblnk;

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vga_o <= '0;
    end else begin
      vga_o <= vga_i;
      if (paint) begin
        vga_o.rgb <= COLOR;
      end
    end
  end

endmodule

//--- logic/draw_lives.sv
module draw_lives
  import ship_pkg::*;
(
  input  logic       pclk,
  input  logic       rst_n_i,
  input  logic [1:0] lives_i,
  input  vga_t       vga_i,
  output vga_t       vga_o
);

  logic icon;

  // icon k is lit while k < lives
  always_comb begin
    icon = 1'b0;
    for (int k = 0; k < LIVES_MAX; k++) begin
      if (k < int'(lives_i) &&
          vga_i.hcount >= COORD_W'(LIFE_X) &&
          vga_i.hcount < COORD_W'(LIFE_X + LIFE_SZ) &&
          vga_i.vcount >= COORD_W'(LIFE_Y0 + k * LIFE_PITCH) &&
          vga_i.vcount < COORD_W'(LIFE_Y0 + k * LIFE_PITCH + LIFE_SZ)) begin
        icon = 1'b1;
      end
    end
  end

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vga_o <= '0;
    end else begin
      vga_o <= vga_i;
      if (icon && !vga_i.hblnk && !vga_i.vblnk) begin
        vga_o.rgb <= LIFE_RGB;
      end
    end
  end

endmodule

//--- logic/ship_layer.sv
module ship_layer
  import ship_pkg::*;
(
  input  logic                 pclk,
  input  logic                 rst_n_i,
  input  logic                 left_i,
  input  logic                 right_i,
  input  logic                 fire_i,
  input  point_t [ENEMY_N-1:0] enemy_i,
  input  vga_t                 vga_i,
  output vga_t                 vga_o,
  output obj_t                 missile_o,
  output logic [1:0]           lives_o
);

  logic               frame_tick;
  logic [COORD_W-1:0] ship_x;
  logic               dead;
  obj_t               ship_obj;
  vga_t               vga_ship;
  vga_t               vga_missile;

  // ship hidden while dead or out of lives
  assign ship_obj = '{x: ship_x, y: COORD_W'(SHIP_Y), on: !dead};

  ship_ctl u_ship_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .vsync_i      (vga_i.vsync),
    .left_i       (left_i),
    .right_i      (right_i),
    .dead_i       (dead),
    .frame_tick_o (frame_tick),
    .ship_x_o     (ship_x)
  );

  hit_detect u_hit_detect (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .frame_tick_i (frame_tick),
    .ship_x_i     (ship_x),
    .enemy_i      (enemy_i),
    .dead_o       (dead),
    .lives_o      (lives_o)
  );

  missile_ctl u_missile_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .frame_tick_i (frame_tick),
    .fire_i       (fire_i),
    .ship_x_i     (ship_x),
    .dead_i       (dead),
    .missile_o    (missile_o)
  );

  // overlay chain: ship, missile, then life icons on top
  draw_rect #(
    .WIDTH  (SHIP_W),
    .HEIGHT (SHIP_H),
    .COLOR  (SHIP_RGB)
  ) u_draw_ship (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .obj_i   (ship_obj),
    .vga_i   (vga_i),
    .vga_o   (vga_ship)
  );

  draw_rect #(
    .WIDTH  (MIS_W),
    .HEIGHT (MIS_H),
    .COLOR  (MIS_RGB)
  ) u_draw_missile (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .obj_i   (missile_o),
    .vga_i   (vga_ship),
    .vga_o   (vga_missile)
  );

  draw_lives u_draw_lives (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .lives_i (lives_o),
    .vga_i   (vga_missile),
    .vga_o   (vga_o)
  );

endmodule

//--- testbench/ship_layer_assertions.sv
module ship_layer_assertions
  import ship_pkg::*;
(
  input logic       pclk,
  input logic       rst_n_i,
  input vga_t       vga_i,
  input vga_t       vga_o,
  input obj_t       missile_o,
  input logic [1:0] lives_o
);

  int fail_count = 0;

  // three overlay stages from input to output
  vsync_delay: assert property (@(posedge pclk) disable iff (!rst_n_i)
    vga_o.vsync == $past(vga_i.vsync, 3))
  else begin
    $error("vsync on vga_o differs from vga_i three cycles earlier");
    fail_count++;
  end

  lives_never_rise: assert property (@(posedge pclk) disable iff (!rst_n_i)
    lives_o <= $past(lives_o))
  else begin
    $error("lives_o went up outside reset");
    fail_count++;
  end

  // a ship with no lives cannot fire
  no_launch_when_over: assert property (@(posedge pclk) disable iff (!rst_n_i)
    $rose(missile_o.on) |-> lives_o != 2'd0)
  else begin
    $error("missile launched with zero lives");
    fail_count++;
  end

endmodule

bind ship_layer ship_layer_assertions u_assertions (
  .pclk      (pclk),
  .rst_n_i   (rst_n_i),
  .vga_i     (vga_i),
  .vga_o     (vga_o),
  .missile_o (missile_o),
  .lives_o   (lives_o)
);

//--- testbench/ship_layer_tb.sv
module ship_layer_tb
  import ship_pkg::*;
();

  // one row of the vector file with the most significant field first
  typedef struct packed {
    logic [7:0]  reps;
    logic [3:0]  ctrl;
    logic [11:0] e0x;
    logic [11:0] e0y;
    logic [11:0] e1x;
    logic [11:0] e1y;
    logic [11:0] e2x;
    logic [11:0] e2y;
    logic [11:0] ph;
    logic [11:0] pv;
    logic [11:0] rgb;
    logic [3:0]  lives;
    logic [3:0]  on;
    logic [11:0] my;
  } vec_t;

  logic                 pclk;
  logic                 rst_n;
  logic                 left;
  logic                 right;
  logic                 fire;
  point_t [ENEMY_N-1:0] enemy;
  vga_t                 vga_drv;
  vga_t                 vga_out;
  obj_t                 missile;
  logic [1:0]           lives;

  logic [139:0] vec_mem [64];
  vec_t         v;
  int           n_vec;
  int           total_frames;
  logic         vec_ready;
  int           errors;
  int           row_errors;

  ship_layer ship_layer_inst (
    .pclk      (pclk),
    .rst_n_i   (rst_n),
    .left_i    (left),
    .right_i   (right),
    .fire_i    (fire),
    .enemy_i   (enemy),
    .vga_i     (vga_drv),
    .vga_o     (vga_out),
    .missile_o (missile),
    .lives_o   (lives)
  );

  initial begin
    pclk = 1'b0;
    forever #20 pclk = ~pclk;
  end

  task automatic next_cycle();
    @(posedge pclk);
    #2;
  endtask

  task automatic drive_pixel(input logic [COORD_W-1:0] h, input logic [COORD_W-1:0] vc,
                             input logic vs, input logic blank);
    vga_drv = '{vcount: vc, vsync: vs, vblnk: blank, hcount: h,
                hsync: blank, hblnk: blank, rgb: '0};
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
      row_errors++;
    end
  endtask

  // one short frame per tick and then the probe pixel
  task automatic run_row(input vec_t r);
    left     = r.ctrl[3];
    right    = r.ctrl[2];
    fire     = r.ctrl[1];
    enemy[0] = '{x: r.e0x[COORD_W-1:0], y: r.e0y[COORD_W-1:0]};
    enemy[1] = '{x: r.e1x[COORD_W-1:0], y: r.e1y[COORD_W-1:0]};
    enemy[2] = '{x: r.e2x[COORD_W-1:0], y: r.e2y[COORD_W-1:0]};
    for (int f = 0; f < int'(r.reps); f++) begin
      drive_pixel('0, '0, 1'b1, 1'b0);
      next_cycle();
      next_cycle();
      if (f < int'(r.reps) - 1) begin
        drive_pixel('0, '0, 1'b0, 1'b0);
        next_cycle();
      end
    end
    drive_pixel(r.ph[COORD_W-1:0], r.pv[COORD_W-1:0], 1'b0, r.ctrl[0]);
    // three overlay stages
    repeat (3) next_cycle();
  endtask

  task automatic compare_row(input vec_t r);
    check("rgb", 32'(vga_out.rgb), 32'(r.rgb));
    check("hcount", 32'(vga_out.hcount), 32'(r.ph));
    check("vcount", 32'(vga_out.vcount), 32'(r.pv));
    check("sync and blank", 32'({vga_out.vsync, vga_out.vblnk, vga_out.hsync, vga_out.hblnk}),
          32'({1'b0, r.ctrl[0], r.ctrl[0], r.ctrl[0]}));
    check("lives", 32'(lives), 32'(r.lives));
    check("missile on", 32'(missile.on), 32'(r.on));
    // y only means something while the missile flies
    if (r.on[0]) begin
      check("missile y", 32'(missile.y), 32'(r.my));
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    left         = 1'b0;
    right        = 1'b0;
    fire         = 1'b0;
    enemy        = '0;
    vga_drv      = '0;
    errors       = 0;
    row_errors   = 0;
    n_vec        = 0;
    total_frames = 0;
    vec_ready    = 1'b0;
    $readmemh("testbench/ship_layer_vectors.txt", vec_mem);
    // a row with zero frames ends the list
    while (n_vec < 64 && vec_mem[n_vec][139:132] != 8'h00) begin
      total_frames += int'(vec_mem[n_vec][139:132]);
      n_vec++;
    end
    vec_ready = 1'b1;
    repeat (16) @(posedge pclk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    for (int i = 0; i < n_vec; i++) begin
      v          = vec_mem[i];
      row_errors = 0;
      run_row(v);
      compare_row(v);
      if (row_errors == 0) begin
        $display("test %0d: ok", i);
      end else begin
        $display("test %0d: %0d mismatches", i, row_errors);
      end
    end
    errors += ship_layer_inst.u_assertions.fail_count;
    $display("%0d tests, %0d errors", n_vec, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog with a generous budget per frame
  initial begin
    wait (vec_ready === 1'b1);
    repeat (16 + 20 * total_frames) @(posedge pclk);
    $display("timeout: the vectors did not complete within %0d frames", total_frames);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- testbench/ship_layer_vectors.txt
// frames _ ctrl (left right fire blank) _ enemy0 x y _ enemy1 x y _ enemy2 x y
// _ probe h v _ rgb _ lives _ missile on _ missile y ; frames 00 ends the list
01_0_000_000_000_000_000_000_180_21C_0F0_3_0_000
01_0_000_000_000_000_000_000_01E_096_F00_3_0_000
01_1_000_000_000_000_000_000_01E_096_000_3_0_000
01_4_000_000_000_000_000_000_184_21C_0F0_3_0_000
01_4_000_000_000_000_000_000_187_21C_000_3_0_000
01_2_000_000_000_000_000_000_196_210_FF0_3_1_210
01_2_000_000_000_000_000_000_199_208_FF0_3_1_208
40_0_000_000_000_000_000_000_196_008_FF0_3_1_008
01_0_000_000_000_000_000_000_196_000_FF0_3_1_000
01_0_000_000_000_000_000_000_196_000_000_3_0_000
70_8_000_000_000_000_000_000_000_21C_0F0_3_0_000
01_0_00A_226_000_000_000_000_000_21C_000_2_0_000
03_2_000_000_000_000_000_000_000_21C_000_2_0_000
01_0_000_000_000_000_000_000_000_21C_0F0_2_0_000
01_0_000_000_000_000_000_000_01E_096_000_2_0_000
01_0_00A_226_000_000_000_000_000_21C_000_1_0_000
04_0_000_000_000_000_000_000_000_21C_0F0_1_0_000
01_0_00A_226_000_000_000_000_000_21C_000_0_0_000
08_A_000_000_000_000_000_000_000_21C_000_0_0_000
01_0_000_000_000_000_000_000_01E_032_000_0_0_000
00_0_000_000_000_000_000_000_000_000_000_0_0_000

//--- all.f
logic/ship_pkg.sv
logic/ship_ctl.sv
logic/hit_detect.sv
logic/missile_ctl.sv
logic/draw_rect.sv
logic/draw_lives.sv
logic/ship_layer.sv
testbench/ship_layer_assertions.sv
testbench/ship_layer_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = ship_layer_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
